//--- Bender.yml
package:
  name: rocc_dma

sources:
  - src/rocc_dma_pkg.sv
  - src/burst_buffer.sv
  - src/mem_req_arbiter.sv
  - src/dma_load_engine.sv
  - src/dma_store_engine.sv
  - src/rocc_cmd_decoder.sv
  - src/rocc_dma_top.sv
  - target: test
    files:
      - verification/rocc_dma_properties.sv
      - verification/rocc_dma_tb.sv

//--- src.f
src/rocc_dma_pkg.sv
src/burst_buffer.sv
src/mem_req_arbiter.sv
src/dma_load_engine.sv
src/dma_store_engine.sv
src/rocc_cmd_decoder.sv
src/rocc_dma_top.sv
verification/rocc_dma_properties.sv
verification/rocc_dma_tb.sv

//--- src/burst_buffer.sv
// contents are undefined after reset; rdata only changes on a read enable
module burst_buffer #(
  parameter int LONG_BURST = 1024
) (
  input  logic                          clock,
  input  logic                          we,
  input  logic                          wbank,
  input  logic [$clog2(LONG_BURST)-1:0] windex,
  input  logic [rocc_dma_pkg::XLEN-1:0] wdata,
  input  logic                          re,
  input  logic                          rbank,
  input  logic [$clog2(LONG_BURST)-1:0] rindex,
  output logic [rocc_dma_pkg::XLEN-1:0] rdata
);
  import rocc_dma_pkg::*;

  // two banks of one long burst each
  logic [XLEN-1:0] mem [0:1][0:LONG_BURST-1];

  always_ff @(posedge clock)
  begin
    if (we)
      mem[wbank][windex] <= wdata;
    if (re)
      rdata <= mem[rbank][rindex];
  end

endmodule

//--- src/dma_load_engine.sv
// read responses must return in request order; responses with a foreign tag are ignored
module dma_load_engine #(
  parameter int LONG_BURST = 1024
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              start,
  input  rocc_dma_pkg::burst_job_t          job,
  output logic                              req_valid,
  input  logic                              req_ready,
  output rocc_dma_pkg::mem_req_t            req,
  input  logic                              mem_resp_valid,
  input  rocc_dma_pkg::mem_resp_t           mem_resp,
  output logic                              buf_we,
  output logic                              buf_bank,
  output logic [$clog2(LONG_BURST)-1:0]     buf_index,
  output logic [rocc_dma_pkg::XLEN-1:0]     buf_wdata,
  output logic                              busy,
  output logic                              done
);
  import rocc_dma_pkg::*;

  localparam int IDX_W = $clog2(LONG_BURST);
  localparam int CNT_W = $clog2(LONG_BURST + 1);

  typedef enum logic [1:0] {idle, requesting, draining} state_e;

  state_e           state;
  logic [XLEN-1:0]  addr_q;
  logic [TAG_W-1:0] tag_q;
  logic             bank_q;
  logic [CNT_W-1:0] words_q;
  logic [CNT_W-1:0] req_cnt;
  logic [CNT_W-1:0] rsp_cnt;
  logic             req_fire;
  logic             last_req;
  logic             rsp_hit;
  logic             last_rsp;

  assign req_valid = state == requesting;
  assign req_fire  = req_valid && req_ready;
  assign last_req  = req_cnt == words_q - CNT_W'(1);
  assign rsp_hit   = mem_resp_valid && (state != idle) && (mem_resp.tag == tag_q);
  assign last_rsp  = rsp_hit && (rsp_cnt == words_q - CNT_W'(1));

  assign req = '{addr: addr_q, tag: tag_q, cmd: mem_read, data: '0};

  // returned words go straight into the bank
  assign buf_we    = rsp_hit;
  assign buf_bank  = bank_q;
  assign buf_index = rsp_cnt[IDX_W-1:0];
  assign buf_wdata = mem_resp.data;

  assign busy = state != idle;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state   <= idle;
      req_cnt <= '0;
      rsp_cnt <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= last_rsp;
      if (start)
      begin
        state   <= requesting;
        req_cnt <= '0;
        rsp_cnt <= '0;
      end
      else
      begin
        if (req_fire)
        begin
          req_cnt <= req_cnt + CNT_W'(1);
          if (last_req)
            state <= draining;
        end
        if (rsp_hit)
          rsp_cnt <= rsp_cnt + CNT_W'(1);
        // last word back ends the burst from either state
        if (last_rsp)
          state <= idle;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (start)
    begin
      addr_q  <= job.base;
      tag_q   <= job.tag;
      bank_q  <= job.bank;
      words_q <= job.words[CNT_W-1:0];
    end
    else if (req_fire)
      addr_q <= addr_q + XLEN'(4);
  end

endmodule

//--- src/dma_store_engine.sv
// first write goes out two cycles after start because the buffer read is registered
module dma_store_engine #(
  parameter int LONG_BURST = 1024
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              start,
  input  rocc_dma_pkg::burst_job_t          job,
  output logic                              req_valid,
  input  logic                              req_ready,
  output rocc_dma_pkg::mem_req_t            req,
  output logic                              buf_re,
  output logic                              buf_bank,
  output logic [$clog2(LONG_BURST)-1:0]     buf_index,
  input  logic [rocc_dma_pkg::XLEN-1:0]     buf_rdata,
  output logic                              busy,
  output logic                              done
);
  import rocc_dma_pkg::*;

  localparam int IDX_W = $clog2(LONG_BURST);
  localparam int CNT_W = $clog2(LONG_BURST + 1);

  typedef enum logic [1:0] {idle, fetch, issue} state_e;

  state_e           state;
  logic [XLEN-1:0]  addr_q;
  logic [TAG_W-1:0] tag_q;
  logic             bank_q;
  logic [CNT_W-1:0] words_q;
  logic [CNT_W-1:0] idx_q;
  logic [CNT_W-1:0] idx_next;
  logic             req_fire;
  logic             last;

  assign req_valid = state == issue;
  assign req_fire  = req_valid && req_ready;
  assign last      = idx_q == words_q - CNT_W'(1);
  assign idx_next  = idx_q + CNT_W'(1);

  // write data comes straight from the buffer output register
  assign req = '{addr: addr_q, tag: tag_q, cmd: mem_write, data: buf_rdata};

  // prefetch the next word as soon as the current one is taken,
  // the read register holds its value while stalled
  assign buf_re    = (state == fetch) || (req_fire && !last);
  assign buf_bank  = bank_q;
  assign buf_index = (state == fetch) ? idx_q[IDX_W-1:0] : idx_next[IDX_W-1:0];

  assign busy = state != idle;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state <= idle;
      idx_q <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= req_fire && last;
      case (state)
        idle:
        begin
          if (start)
          begin
            state <= fetch;
            idx_q <= '0;
          end
        end
        fetch:
          state <= issue;
        issue:
        begin
          if (req_fire)
          begin
            if (last)
              state <= idle;
            else
              idx_q <= idx_next;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (start)
    begin
      addr_q  <= job.base;
      tag_q   <= job.tag;
      bank_q  <= job.bank;
      words_q <= job.words[CNT_W-1:0];
    end
    else if (req_fire)
      addr_q <= addr_q + XLEN'(4);
  end

endmodule

//--- src/mem_req_arbiter.sv
// requesters must hold valid until ready; ready may depend on valid but not the reverse
module mem_req_arbiter (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   load_valid,
  output logic                   load_ready,
  input  rocc_dma_pkg::mem_req_t load_req,
  input  logic                   store_valid,
  output logic                   store_ready,
  input  rocc_dma_pkg::mem_req_t store_req,
  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output rocc_dma_pkg::mem_req_t mem_req
);

  logic lock_q;
  logic lock_store_q;
  logic prio_store_q;
  logic grant_store;

  // a stalled request keeps the port, otherwise round robin on contention
  always_comb
  begin
    if (lock_q)
      grant_store = lock_store_q;
    else if (load_valid && store_valid)
      grant_store = prio_store_q;
    else
      grant_store = store_valid;
  end

  assign mem_req_valid = grant_store ? store_valid : load_valid;
  assign mem_req       = grant_store ? store_req : load_req;
  assign load_ready    = mem_req_ready && !grant_store;
  assign store_ready   = mem_req_ready && grant_store;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      lock_q       <= 1'b0;
      lock_store_q <= 1'b0;
      prio_store_q <= 1'b0;
    end
    else if (mem_req_valid && mem_req_ready)
    begin
      lock_q       <= 1'b0;
      prio_store_q <= !grant_store;
    end
    else if (mem_req_valid)
    begin
      lock_q       <= 1'b1;
      lock_store_q <= grant_store;
    end
  end

endmodule

//--- src/rocc_cmd_decoder.sv
// one response may be pending at a time; a load and a store may run only on different banks
module rocc_cmd_decoder #(
  parameter int SHORT_BURST = 128,
  parameter int LONG_BURST  = 1024
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  rocc_dma_pkg::rocc_cmd_t  cmd,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output rocc_dma_pkg::rocc_resp_t resp,
  input  logic                     load_busy,
  input  logic                     store_busy,
  input  logic                     load_done,
  input  logic                     store_done,
  output logic                     load_start,
  output logic                     store_start,
  output rocc_dma_pkg::burst_job_t load_job,
  output rocc_dma_pkg::burst_job_t store_job,
  output logic                     interrupt
);
  import rocc_dma_pkg::*;

  logic             run_q;
  logic             long_burst_q;
  logic [TAG_W-1:0] tag_q;
  logic             load_bank_q;
  logic             store_bank_q;
  logic             int_pending;
  logic             is_custom;
  logic             is_config;
  logic             is_load;
  logic             is_store;
  logic             is_status;
  logic             cmd_bank;
  logic             blocked;
  logic             accept;
  logic [15:0]      burst_words;
  burst_job_t       next_job;

  assign is_custom = cmd.opcode == custom0;
  assign is_config = is_custom && (cmd.funct == set_config);
  assign is_load   = is_custom && (cmd.funct == load);
  assign is_store  = is_custom && (cmd.funct == store);
  assign is_status = is_custom && (cmd.funct == status);
  assign cmd_bank  = cmd.rs2[0];

  // engine already running, or the other engine owns the requested bank
  assign blocked = (is_load && (load_busy || (store_busy && cmd_bank == store_bank_q)))
                || (is_store && (store_busy || (load_busy && cmd_bank == load_bank_q)));

  assign cmd_ready = run_q && !resp_valid && !blocked;
  assign accept    = cmd_valid && cmd_ready;

  assign burst_words = long_burst_q ? 16'(LONG_BURST) : 16'(SHORT_BURST);
  assign next_job    = '{base: cmd.rs1, bank: cmd_bank, words: burst_words, tag: tag_q};

  // engines latch the job in the acceptance cycle
  assign load_start  = accept && is_load;
  assign store_start = accept && is_store;
  assign load_job    = next_job;
  assign store_job   = next_job;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      run_q        <= 1'b0;
      long_burst_q <= 1'b0;
      tag_q        <= '0;
      load_bank_q  <= 1'b0;
      store_bank_q <= 1'b0;
      resp_valid   <= 1'b0;
      interrupt    <= 1'b0;
      int_pending  <= 1'b0;
    end
    else
    begin
      run_q <= 1'b1;
      if (accept && is_config)
        long_burst_q <= cmd.rs1[0];
      if (load_start || store_start)
        tag_q <= (tag_q == TAG_LAST) ? '0 : tag_q + TAG_W'(1);
      if (load_start)
        load_bank_q <= cmd_bank;
      if (store_start)
        store_bank_q <= cmd_bank;

      if (accept && is_custom && cmd.xd)
        resp_valid <= 1'b1;
      else if (resp_ready)
        resp_valid <= 1'b0;

      // a done landing right after a pulse is deferred by one cycle
      if (interrupt)
      begin
        interrupt   <= 1'b0;
        int_pending <= load_done || store_done;
      end
      else
      begin
        interrupt   <= load_done || store_done || int_pending;
        int_pending <= 1'b0;
      end
    end
  end

  // status reports busy flags as seen when the command is taken
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      resp.rd   <= cmd.rd;
      resp.data <= is_status ? {{(XLEN-2){1'b0}}, store_busy, load_busy} : '0;
    end
  end

endmodule

//--- src/rocc_dma_pkg.sv
// 32-bit host and word-only transfers; tags wrap after 63, so only 64 bursts can be told apart
package rocc_dma_pkg;

  localparam int XLEN = 32;
  localparam int TAG_W = 9;
  localparam int MEM_CMD_W = 5;

  // last tag before the counter wraps back to zero
  localparam logic [TAG_W-1:0] TAG_LAST = TAG_W'(63);

  // only custom-0 is decoded, anything else is swallowed
  typedef enum logic [6:0] {
    custom0 = 7'h0b
  } rocc_opcode_e;

  typedef enum logic [6:0] {
    set_config = 7'd0,
    load       = 7'd1,
    status     = 7'd2,
    store      = 7'd3
  } rocc_funct_e;

  typedef enum logic [MEM_CMD_W-1:0] {
    mem_read  = MEM_CMD_W'(0),
    mem_write = MEM_CMD_W'(1)
  } mem_cmd_e;

  // command from the host core
  typedef struct packed {
    rocc_opcode_e      opcode;
    rocc_funct_e       funct;
    logic [4:0]        rd;
    logic              xd;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
  } rocc_cmd_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } rocc_resp_t;

  // request toward the data cache
  typedef struct packed {
    logic [XLEN-1:0]  addr;
    logic [TAG_W-1:0] tag;
    mem_cmd_e         cmd;
    logic [XLEN-1:0]  data;
  } mem_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  data;
  } mem_resp_t;

  // one burst as handed from the decoder to an engine
  typedef struct packed {
    logic [XLEN-1:0]  base;
    logic             bank;
    logic [15:0]      words;
    logic [TAG_W-1:0] tag;
  } burst_job_t;

endpackage

//--- src/rocc_dma_top.sv
// LONG_BURST sets the bank depth and should be a power of two; SHORT_BURST must not exceed it
module rocc_dma_top #(
  parameter int SHORT_BURST = 128,
  parameter int LONG_BURST  = 1024
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  rocc_dma_pkg::rocc_cmd_t  cmd,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output rocc_dma_pkg::rocc_resp_t resp,
  output logic                     mem_req_valid,
  input  logic                     mem_req_ready,
  output rocc_dma_pkg::mem_req_t   mem_req,
  input  logic                     mem_resp_valid,
  input  rocc_dma_pkg::mem_resp_t  mem_resp,
  output logic                     interrupt
);
  import rocc_dma_pkg::*;

  localparam int IDX_W = $clog2(LONG_BURST);

  logic             load_start;
  logic             store_start;
  burst_job_t       load_job;
  burst_job_t       store_job;
  logic             load_busy;
  logic             store_busy;
  logic             load_done;
  logic             store_done;
  logic             load_req_valid;
  logic             load_req_ready;
  mem_req_t         load_req;
  logic             store_req_valid;
  logic             store_req_ready;
  mem_req_t         store_req;
  logic             buf_we;
  logic             buf_wbank;
  logic [IDX_W-1:0] buf_windex;
  logic [XLEN-1:0]  buf_wdata;
  logic             buf_re;
  logic             buf_rbank;
  logic [IDX_W-1:0] buf_rindex;
  logic [XLEN-1:0]  buf_rdata;

  rocc_cmd_decoder #(.SHORT_BURST(SHORT_BURST), .LONG_BURST(LONG_BURST)) u_decoder (
    .clock, .reset, .cmd_valid, .cmd_ready, .cmd, .resp_valid, .resp_ready, .resp,
    .load_busy, .store_busy, .load_done, .store_done,
    .load_start, .store_start, .load_job, .store_job, .interrupt
  );

  dma_load_engine #(.LONG_BURST(LONG_BURST)) u_load (
    .clock, .reset, .start(load_start), .job(load_job),
    .req_valid(load_req_valid), .req_ready(load_req_ready), .req(load_req),
    .mem_resp_valid, .mem_resp,
    .buf_we, .buf_bank(buf_wbank), .buf_index(buf_windex), .buf_wdata,
    .busy(load_busy), .done(load_done)
  );

  dma_store_engine #(.LONG_BURST(LONG_BURST)) u_store (
    .clock, .reset, .start(store_start), .job(store_job),
    .req_valid(store_req_valid), .req_ready(store_req_ready), .req(store_req),
    .buf_re, .buf_bank(buf_rbank), .buf_index(buf_rindex), .buf_rdata,
    .busy(store_busy), .done(store_done)
  );

  mem_req_arbiter u_arbiter (
    .clock, .reset,
    .load_valid(load_req_valid), .load_ready(load_req_ready), .load_req,
    .store_valid(store_req_valid), .store_ready(store_req_ready), .store_req,
    .mem_req_valid, .mem_req_ready, .mem_req
  );

  burst_buffer #(.LONG_BURST(LONG_BURST)) u_buffer (
    .clock,
    .we(buf_we), .wbank(buf_wbank), .windex(buf_windex), .wdata(buf_wdata),
    .re(buf_re), .rbank(buf_rbank), .rindex(buf_rindex), .rdata(buf_rdata)
  );

endmodule

//--- verification/rocc_dma_properties.sv
// handshake checks for rocc_dma_top; sampled on the rising clock and off while reset is high
module rocc_dma_properties (
  input logic                     clock,
  input logic                     reset,
  input logic                     mem_req_valid,
  input logic                     mem_req_ready,
  input rocc_dma_pkg::mem_req_t   mem_req,
  input logic                     resp_valid,
  input logic                     resp_ready,
  input rocc_dma_pkg::rocc_resp_t resp,
  input logic                     interrupt
);

  int failures = 0;

  // stalled request keeps its payload
  req_stable: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
  else
  begin
    failures++;
    $error("memory request changed or dropped while waiting for ready");
  end

  resp_stable: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
  else
  begin
    failures++;
    $error("response changed or dropped while waiting for resp_ready");
  end

  int_pulse: assert property (@(posedge clock) disable iff (reset) interrupt |=> !interrupt)
  else
  begin
    failures++;
    $error("interrupt held high for two cycles");
  end

endmodule

bind rocc_dma_top rocc_dma_properties props (.*);

//--- verification/rocc_dma_tb.sv
// bursts are set to 8 and 32 words; the memory model answers reads in order and only stores writes
module rocc_dma_tb;
  import rocc_dma_pkg::*;

  localparam int SHORT_WORDS = 8;
  localparam int LONG_WORDS  = 32;
  // burst words and commands over all five tests
  localparam int TOTAL_WORDS = 136;
  localparam int TOTAL_CMDS  = 25;
  localparam int CYCLE_LIMIT = 20 * (TOTAL_WORDS + TOTAL_CMDS);

  logic       clock;
  logic       reset;
  logic       cmd_valid;
  logic       cmd_ready;
  rocc_cmd_t  cmd;
  logic       resp_valid;
  logic       resp_ready = 1'b0;
  rocc_resp_t resp;
  logic       mem_req_valid;
  logic       mem_req_ready = 1'b0;
  mem_req_t   mem_req;
  logic       mem_resp_valid = 1'b0;
  mem_resp_t  mem_resp = '0;
  logic       interrupt;

  integer seed = 38748;
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;

  // sparse memory and the in-order read return queue
  logic [XLEN-1:0] mem_model [logic [XLEN-1:0]];
  mem_resp_t       read_q [$];
  int              due_q [$];
  logic [XLEN-1:0] src_bases [5] = '{32'h1000, 32'h3000, 32'h5000, 32'h6000, 32'h7000};

  // reference model state
  logic            long_cfg = 1'b0;
  int              next_tag = 0;
  logic            ld_busy = 1'b0;
  logic            st_busy = 1'b0;
  logic [XLEN-1:0] ld_base;
  logic [XLEN-1:0] st_base;
  logic            ld_bank;
  logic            st_bank;
  int              ld_tag;
  int              st_tag;
  int              ld_words;
  int              st_words;
  int              ld_req_idx;
  int              ld_rsp_idx;
  int              st_idx;
  logic [XLEN-1:0] bank_model [0:1][0:LONG_WORDS-1];
  rocc_resp_t      exp_resp_q [$];
  int              n_reads = 0;
  int              n_writes = 0;
  int              n_resps = 0;
  int              exp_ints = 0;
  int              got_ints = 0;
  rocc_cmd_t       mixed_cmds [8];

  rocc_dma_top #(.SHORT_BURST(SHORT_WORDS), .LONG_BURST(LONG_WORDS)) dut (
    .clock, .reset, .cmd_valid, .cmd_ready, .cmd, .resp_valid, .resp_ready, .resp,
    .mem_req_valid, .mem_req_ready, .mem_req, .mem_resp_valid, .mem_resp, .interrupt
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the DUT did not finish its transfers", cycles);
      $display("test failed");
      $finish;
    end
  end

  // unwritten words follow a pattern of the full address
  function automatic logic [XLEN-1:0] read_model_word(input logic [XLEN-1:0] addr);
    if (mem_model.exists(addr))
      return mem_model[addr];
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_96e1;
  endfunction

  function automatic rocc_cmd_t make_cmd(input rocc_funct_e funct, input logic [4:0] rd,
                                         input logic xd, input logic [XLEN-1:0] rs1,
                                         input logic [XLEN-1:0] rs2);
    return '{opcode: custom0, funct: funct, rd: rd, xd: xd, rs1: rs1, rs2: rs2};
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_resp(input rocc_resp_t got, input rocc_resp_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: resp got rd %0d data %h, expected rd %0d data %h",
               $time, got.rd, got.data, exp.rd, exp.data);
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: mem_req got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp)
      flag_error($sformatf("expected %0d %s, saw %0d", exp, what, got));
  endtask

  // predicts the response and starts bursts in the model
  task automatic model_command(input rocc_cmd_t c);
    logic [XLEN-1:0] data;
    int words;
    int i;
    data = '0;
    words = long_cfg ? LONG_WORDS : SHORT_WORDS;
    // no command may be taken while a response waits
    if (exp_resp_q.size() != 0)
      flag_error("command accepted while a response was still pending");
    if (c.opcode != custom0)
      return;
    case (c.funct)
      set_config:
        long_cfg = c.rs1[0];
      load:
      begin
        if (ld_busy || (st_busy && st_bank == c.rs2[0]))
          flag_error("load accepted while the load engine or its bank was busy");
        ld_base = c.rs1;
        ld_bank = c.rs2[0];
        ld_words = words;
        ld_tag = next_tag;
        ld_req_idx = 0;
        ld_rsp_idx = 0;
        ld_busy = 1'b1;
        for (i = 0; i < words; i++)
          bank_model[c.rs2[0]][i] = read_model_word(c.rs1 + XLEN'(4 * i));
        next_tag = (next_tag == 63) ? 0 : next_tag + 1;
      end
      store:
      begin
        if (st_busy || (ld_busy && ld_bank == c.rs2[0]))
          flag_error("store accepted while the store engine or its bank was busy");
        st_base = c.rs1;
        st_bank = c.rs2[0];
        st_words = words;
        st_tag = next_tag;
        st_idx = 0;
        st_busy = 1'b1;
        next_tag = (next_tag == 63) ? 0 : next_tag + 1;
      end
      status:
        data = {{(XLEN-2){1'b0}}, st_busy, ld_busy};
      default:
        ;
    endcase
    if (c.xd)
      exp_resp_q.push_back('{rd: c.rd, data: data});
  endtask

  // ready signals and read data, driven just after the clock edge
  always @(posedge clock)
  begin
    #1;
    mem_req_ready = ($random(seed) & 3) != 0;
    resp_ready = ($random(seed) & 1) != 0;
    if (read_q.size() > 0 && due_q[0] <= cycles)
    begin
      mem_resp_valid = 1'b1;
      mem_resp = read_q.pop_front();
      void'(due_q.pop_front());
    end
    else
      mem_resp_valid = 1'b0;
  end

  // monitor; every handshake is settled by the falling edge
  always @(negedge clock)
  begin
    logic     ld_last;
    logic     st_last;
    mem_req_t exp_req;
    ld_last = 1'b0;
    st_last = 1'b0;
    if (cmd_valid && cmd_ready)
      model_command(cmd);
    if (mem_req_valid && mem_req_ready)
    begin
      if (mem_req.cmd == mem_read)
      begin
        if (!ld_busy || ld_req_idx >= ld_words)
          flag_error("read request issued with no load burst left");
        else
        begin
          exp_req = '{addr: ld_base + XLEN'(4 * ld_req_idx), tag: TAG_W'(ld_tag),
                      cmd: mem_read, data: '0};
          check_mem_req(mem_req, exp_req);
          read_q.push_back('{tag: mem_req.tag, data: read_model_word(mem_req.addr)});
          due_q.push_back(cycles + 1 + ($random(seed) & 3));
          ld_req_idx++;
          n_reads++;
        end
      end
      else if (!st_busy)
        flag_error("write request issued with no store burst running");
      else
      begin
        exp_req = '{addr: st_base + XLEN'(4 * st_idx), tag: TAG_W'(st_tag),
                    cmd: mem_write, data: bank_model[st_bank][st_idx]};
        check_mem_req(mem_req, exp_req);
        mem_model[mem_req.addr] = mem_req.data;
        st_last = st_idx == st_words - 1;
        st_idx++;
        n_writes++;
      end
    end
    if (mem_resp_valid)
    begin
      ld_rsp_idx++;
      ld_last = ld_rsp_idx == ld_words;
    end
    if (ld_last)
      ld_busy = 1'b0;
    if (st_last)
      st_busy = 1'b0;
    // done pulses in the same cycle merge into one interrupt
    if (ld_last || st_last)
      exp_ints++;
    if (resp_valid && resp_ready)
    begin
      n_resps++;
      if (exp_resp_q.size() == 0)
        flag_error("response seen with no command expecting one");
      else
        check_resp(resp, exp_resp_q.pop_front());
    end
    if (interrupt)
      got_ints++;
  end

  task automatic send_cmd(input rocc_cmd_t c);
    cmd = c;
    cmd_valid = 1'b1;
    do
      @(negedge clock);
    while (!cmd_ready);
    @(posedge clock);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do
      @(posedge clock);
    while (ld_busy || st_busy || exp_resp_q.size() != 0 || got_ints < exp_ints);
    #1;
  endtask

  task automatic compare_region(input logic [XLEN-1:0] dst, input logic [XLEN-1:0] src,
                                input int words);
    int i;
    for (i = 0; i < words; i++)
      check_word($sformatf("mem[%h]", dst + XLEN'(4 * i)), read_model_word(dst + XLEN'(4 * i)),
                 read_model_word(src + XLEN'(4 * i)));
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("%s: %0d errors", name, errors - err_start);
  endtask

  task automatic run_round_trip(input string name, input logic long_burst,
                                input logic [XLEN-1:0] src, input logic [XLEN-1:0] dst);
    int err_start;
    int reads_start;
    int writes_start;
    int words;
    err_start = errors;
    reads_start = n_reads;
    writes_start = n_writes;
    words = long_burst ? LONG_WORDS : SHORT_WORDS;
    send_cmd(make_cmd(set_config, 5'd1, 1'b1, {31'd0, long_burst}, '0));
    send_cmd(make_cmd(load, 5'd2, 1'b1, src, '0));
    wait_idle();
    send_cmd(make_cmd(store, 5'd3, 1'b0, dst, '0));
    wait_idle();
    expect_count("read requests", n_reads - reads_start, words);
    expect_count("write requests", n_writes - writes_start, words);
    compare_region(dst, src, words);
    finish_test(name, err_start);
  endtask

  task automatic run_mixed_responses();
    int err_start;
    int resps_start;
    int expected;
    int i;
    err_start = errors;
    resps_start = n_resps;
    expected = 0;
    for (i = 0; i < 8; i++)
    begin
      if (mixed_cmds[i].xd && mixed_cmds[i].opcode == custom0)
        expected++;
      send_cmd(mixed_cmds[i]);
    end
    wait_idle();
    expect_count("responses", n_resps - resps_start, expected);
    finish_test("responses under random resp_ready", err_start);
  endtask

  task automatic run_status();
    int err_start;
    err_start = errors;
    send_cmd(make_cmd(set_config, 5'd1, 1'b0, '0, '0));
    send_cmd(make_cmd(load, 5'd2, 1'b0, 32'h5000, '0));
    // taken while the load is still in flight
    send_cmd(make_cmd(status, 5'd4, 1'b1, '0, '0));
    // both wait for the engine that owns bank 0
    send_cmd(make_cmd(store, 5'd6, 1'b0, 32'ha000, 32'd0));
    send_cmd(make_cmd(load, 5'd7, 1'b0, 32'h5000, 32'd0));
    wait_idle();
    send_cmd(make_cmd(status, 5'd5, 1'b1, '0, '0));
    wait_idle();
    compare_region(32'ha000, 32'h5000, SHORT_WORDS);
    finish_test("status", err_start);
  endtask

  task automatic run_overlap();
    int err_start;
    int ints_start;
    int exp_start;
    err_start = errors;
    send_cmd(make_cmd(set_config, 5'd1, 1'b0, '0, '0));
    send_cmd(make_cmd(load, 5'd2, 1'b0, 32'h6000, 32'd0));
    wait_idle();
    ints_start = got_ints;
    exp_start = exp_ints;
    send_cmd(make_cmd(load, 5'd3, 1'b1, 32'h7000, 32'd1));
    send_cmd(make_cmd(store, 5'd4, 1'b1, 32'h8000, 32'd0));
    wait_idle();
    expect_count("interrupts", got_ints - ints_start, exp_ints - exp_start);
    send_cmd(make_cmd(store, 5'd5, 1'b0, 32'h9000, 32'd1));
    wait_idle();
    compare_region(32'h8000, 32'h6000, SHORT_WORDS);
    compare_region(32'h9000, 32'h7000, SHORT_WORDS);
    finish_test("overlap", err_start);
  endtask

  initial
  begin
    int i;
    int j;
    int total;
    logic [31:0] r;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    // source data for every load region
    for (i = 0; i < 5; i++)
      for (j = 0; j < LONG_WORDS; j++)
        mem_model[src_bases[i] + XLEN'(4 * j)] = $random(seed);
    for (i = 0; i < 8; i++)
    begin
      r = $random(seed);
      mixed_cmds[i] = make_cmd(rocc_funct_e'(r[0] ? status : set_config), r[6:2], r[1],
                               {31'd0, r[7]}, '0);
    end
    // a foreign opcode must be swallowed
    mixed_cmds[7].opcode = rocc_opcode_e'(7'h2b);
    mixed_cmds[7].xd = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    run_round_trip("short round trip", 1'b0, 32'h1000, 32'h2000);
    run_round_trip("long burst", 1'b1, 32'h3000, 32'h4000);
    run_mixed_responses();
    run_status();
    run_overlap();

    total = errors + dut.props.failures;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, dut.props.failures);
    if (total == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
